//--- rtl/retire_pkg.sv
// Shared widths, instruction classes, exception codes and stage payload types for the core back end
package retire_pkg;

    localparam int xlen      = 32;                        // Data and address width
    localparam int tag_width = 4;                         // Retire tag width

    // Upper two bits of the class select the execution unit
    typedef enum logic [1:0] {
        memory = 2'b00,
        branch = 2'b01,
        alu    = 2'b10,
        system = 2'b11
    } xu_sel_t;

    typedef enum logic [4:0] {
        LB       = 5'b00_000,                             // Loads and stores share the memory unit
        LBU      = 5'b00_001,
        LH       = 5'b00_010,
        LHU      = 5'b00_011,
        LW       = 5'b00_100,
        SB       = 5'b00_101,
        SH       = 5'b00_110,
        SW       = 5'b00_111,
        JAL_JALR = 5'b01_000,                             // Branch unit
        ADD_OP   = 5'b10_000,                             // ALU
        NOP      = 5'b10_001,
        ECALL    = 5'b11_000,                             // System unit
        EBREAK   = 5'b11_001,
        MRET     = 5'b11_010
    } instr_class;

    typedef enum logic [3:0] {
        NE                  = 4'd0,                       // No exception
        ILLEGAL_INSTRUCTION = 4'd2,
        BREAKPOINT          = 4'd3,
        ECALL_FROM_MMODE    = 4'd11
    } except_code;

    typedef struct packed {
        logic [11:0] imm;                                 // Load and jump immediate
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]  imm_hi;                              // Store immediate [11:5]
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;                              // Store immediate [4:0]
        logic [6:0]  opcode;
    } s_fmt_t;

    typedef union packed {
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } instr_word_u;

    typedef struct packed {
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      rs1_val;
        logic [xlen-1:0]      rs2_val;
        instr_word_u          instr;
        instr_class           iclass;
        logic [tag_width-1:0] tag;                        // Stamped from retire_tag at issue
        logic                 illegal;                    // Flagged by decode
        logic                 we;                         // Register write-back wanted
    } issue_t;

    typedef struct packed {
        logic [xlen-1:0]      result0;                    // Write-back value or store data
        logic [xlen-1:0]      result1;                    // Memory address or jump target
        logic [xlen-1:0]      pc;
        instr_word_u          instr;
        instr_class           iclass;
        logic [tag_width-1:0] tag;
        logic                 we;
        logic                 jump;
        logic                 illegal;
        logic [3:0]           we_mem;                     // Store byte lanes
    } exec_res_t;

endpackage

//--- rtl/exec_unit.sv
// Execute stage: forms address, jump target or sum from an issued packet and launches loads
`timescale 1ns/1ps

module exec_unit (
    input  logic                        issue,             // One decoded instruction this cycle
    input  retire_pkg::issue_t          issue_pkt,
    output logic                        ex_valid,
    output retire_pkg::exec_res_t       ex_res,
    output logic [retire_pkg::xlen-1:0] mem_raddr,         // Word-aligned read address
    output logic                        mem_re
);
    import retire_pkg::*;

    xu_sel_t         xu;                                   // Unit picked from the class
    logic [xlen-1:0] imm_i;                                // Sign-extended I immediate
    logic [xlen-1:0] imm_s;                                // Sign-extended S immediate
    logic [xlen-1:0] base_i;                               // rs1 plus I immediate
    logic [xlen-1:0] mem_addr;                             // Byte address for loads and stores
    logic            is_load;
    logic            is_store;

    assign xu = xu_sel_t'(issue_pkt.iclass[4:3]);

    // Same word, two decodings
    assign imm_i = {{(xlen-12){issue_pkt.instr.i_fmt.imm[11]}}, issue_pkt.instr.i_fmt.imm};
    assign imm_s = {{(xlen-12){issue_pkt.instr.s_fmt.imm_hi[6]}},
                    issue_pkt.instr.s_fmt.imm_hi, issue_pkt.instr.s_fmt.imm_lo};

    assign is_load  = issue_pkt.iclass inside {LB, LBU, LH, LHU, LW};
    assign is_store = issue_pkt.iclass inside {SB, SH, SW};

    assign base_i   = issue_pkt.rs1_val + imm_i;
    assign mem_addr = is_store ? (issue_pkt.rs1_val + imm_s) : base_i;

    assign ex_valid  = issue;
    assign mem_re    = issue && is_load;                   // Data comes back next cycle
    assign mem_raddr = {mem_addr[xlen-1:2], 2'b00};

    always_comb begin
        ex_res         = '0;
        ex_res.pc      = issue_pkt.pc;                     // Carried along untouched
        ex_res.instr   = issue_pkt.instr;
        ex_res.iclass  = issue_pkt.iclass;
        ex_res.tag     = issue_pkt.tag;
        ex_res.we      = issue_pkt.we;
        ex_res.illegal = issue_pkt.illegal;

        case (xu)
            memory: begin
                ex_res.result1 = mem_addr;                 // Retire aligns by the low bits
                ex_res.result0 = issue_pkt.rs2_val;        // Store data
            end
            branch: begin
                ex_res.result1 = {base_i[xlen-1:1], 1'b0}; // JALR clears bit 0
                ex_res.result0 = issue_pkt.pc + 32'd4;     // Link address
                ex_res.jump    = 1'b1;
            end
            alu: begin
                if (issue_pkt.iclass == ADD_OP)
                    ex_res.result0 = issue_pkt.rs1_val + issue_pkt.rs2_val;
            end
            default: ;                                     // System ops carry no result
        endcase

        // Lane enables follow the byte address
        case (issue_pkt.iclass)
            SB:      ex_res.we_mem = 4'b0001 << mem_addr[1:0];
            SH:      ex_res.we_mem = mem_addr[1] ? 4'b1100 : 4'b0011;
            SW:      ex_res.we_mem = 4'b1111;
            default: ex_res.we_mem = 4'b0000;
        endcase
    end

endmodule

//--- rtl/exec_retire_reg.sv
// One-deep pipeline register carrying an executed instruction into the retire stage
`timescale 1ns/1ps

module exec_retire_reg (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ex_valid,
    input  retire_pkg::exec_res_t ex_res,
    output logic                  rt_valid,            // Instruction present in retire
    output retire_pkg::exec_res_t rt_res
);
    import retire_pkg::*;

    // Valid bit is the only control state here
    always_ff @(posedge clk) begin
        if (reset)
            rt_valid <= 1'b0;                          // Stale payload never retires
        else
            rt_valid <= ex_valid;
    end

    // Payload loads every cycle, no stall path
    always_ff @(posedge clk) begin
        rt_res <= ex_res;
    end

endmodule

//--- rtl/retire.sv
// Retire stage: kills wrong-path instructions by tag and drives write-back, stores, jumps and traps
`timescale 1ns/1ps

module retire (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             rt_valid,
    input  retire_pkg::exec_res_t            rt_res,
    input  logic [retire_pkg::xlen-1:0]      mem_rdata,          // Word read one cycle after mem_re
    input  logic                             interrupt_pending,
    output logic                             reg_we,
    output logic [retire_pkg::xlen-1:0]      wr_data,
    output logic                             jump_out,
    output logic [retire_pkg::xlen-1:0]      new_pc,
    output logic [3:0]                       mem_we,
    output logic [retire_pkg::xlen-1:0]      mem_waddr,
    output logic [retire_pkg::xlen-1:0]      mem_wdata,
    output logic                             raise_exception,
    output retire_pkg::except_code           exception_code,
    output logic                             machine_return,
    output logic                             interrupt_ack,
    output logic [retire_pkg::tag_width-1:0] retire_tag
);
    import retire_pkg::*;

    logic [tag_width-1:0] curr_tag;                              // Tag of the live path
    logic                 kept;                                  // Valid and on the live path
    logic [xlen-1:0]      load_data;                             // Aligned and extended load word
    logic                 flow_event;                            // Any redirect this cycle
    xu_sel_t              xu;

    assign retire_tag = curr_tag;
    assign xu         = xu_sel_t'(rt_res.iclass[4:3]);
    assign kept       = rt_valid && (rt_res.tag == curr_tag);

    // Byte and halfword selection from the address low bits
    always_comb begin
        case (rt_res.iclass)
            LB, LBU: begin
                case (rt_res.result1[1:0])
                    2'b11:   load_data[7:0] = mem_rdata[31:24];
                    2'b10:   load_data[7:0] = mem_rdata[23:16];
                    2'b01:   load_data[7:0] = mem_rdata[15:8];
                    default: load_data[7:0] = mem_rdata[7:0];
                endcase
                load_data[31:8] = {24{load_data[7] && rt_res.iclass == LB}};
            end
            LH, LHU: begin
                load_data[15:0]  = rt_res.result1[1] ? mem_rdata[31:16] : mem_rdata[15:0];
                load_data[31:16] = {16{load_data[15] && rt_res.iclass == LH}};
            end
            default: load_data = mem_rdata;                      // LW takes the whole word
        endcase
    end

    // Write-back
    assign reg_we  = kept && rt_res.we;
    assign wr_data = !kept          ? '0 :
                     (xu == memory) ? load_data : rt_res.result0;

    // Jump redirect
    assign jump_out = kept && rt_res.jump;
    assign new_pc   = jump_out ? rt_res.result1 : '0;

    // Store port, quiet unless a kept store
    always_comb begin
        if (kept && rt_res.we_mem != 4'b0000) begin
            mem_we    = rt_res.we_mem;
            mem_waddr = rt_res.result1;
            mem_wdata = rt_res.result0;
        end else begin
            mem_we    = 4'b0000;
            mem_waddr = '0;
            mem_wdata = '0;
        end
    end

    // Fixed priority: illegal, ECALL, EBREAK, MRET, then interrupt
    always_comb begin
        raise_exception = 1'b0;
        exception_code  = NE;
        machine_return  = 1'b0;
        interrupt_ack   = 1'b0;
        if (kept) begin
            if (rt_res.illegal) begin
                raise_exception = 1'b1;
                exception_code  = ILLEGAL_INSTRUCTION;
            end else if (rt_res.iclass == ECALL) begin
                raise_exception = 1'b1;
                exception_code  = ECALL_FROM_MMODE;
            end else if (rt_res.iclass == EBREAK) begin
                raise_exception = 1'b1;
                exception_code  = BREAKPOINT;
            end else if (rt_res.iclass == MRET) begin
                machine_return  = 1'b1;
            end else if (interrupt_pending && !rt_res.jump) begin
                interrupt_ack   = 1'b1;                          // Never taken alongside a jump
            end
        end
    end

    assign flow_event = jump_out || raise_exception || machine_return || interrupt_ack;

    // New tag marks everything issued before the redirect as wrong path
    always_ff @(posedge clk) begin
        if (reset)
            curr_tag <= '0;
        else if (kept && flow_event)
            curr_tag <= curr_tag + 1'b1;
    end

endmodule

//--- rtl/retire_top.sv
// Back-end top level joining execute, the execute-to-retire register and retire
`timescale 1ns/1ps

module retire_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             issue,
    input  retire_pkg::issue_t               issue_pkt,
    output logic [retire_pkg::xlen-1:0]      mem_raddr,
    output logic                             mem_re,
    input  logic [retire_pkg::xlen-1:0]      mem_rdata,
    input  logic                             interrupt_pending,
    output logic                             reg_we,
    output logic [retire_pkg::xlen-1:0]      wr_data,
    output logic                             jump_out,
    output logic [retire_pkg::xlen-1:0]      new_pc,
    output logic [3:0]                       mem_we,
    output logic [retire_pkg::xlen-1:0]      mem_waddr,
    output logic [retire_pkg::xlen-1:0]      mem_wdata,
    output logic                             raise_exception,
    output retire_pkg::except_code           exception_code,
    output logic                             machine_return,
    output logic                             interrupt_ack,
    output logic [retire_pkg::tag_width-1:0] retire_tag
);
    import retire_pkg::*;

    logic      ex_valid;                                   // Execute stage outputs
    exec_res_t ex_res;
    logic      rt_valid;                                   // Retire stage inputs
    exec_res_t rt_res;

    exec_unit u_exec_unit (
        .issue     (issue),
        .issue_pkt (issue_pkt),
        .ex_valid  (ex_valid),
        .ex_res    (ex_res),
        .mem_raddr (mem_raddr),
        .mem_re    (mem_re)
    );

    exec_retire_reg u_exec_retire_reg (
        .clk      (clk),
        .reset    (reset),
        .ex_valid (ex_valid),
        .ex_res   (ex_res),
        .rt_valid (rt_valid),
        .rt_res   (rt_res)
    );

    retire u_retire (
        .clk               (clk),
        .reset             (reset),
        .rt_valid          (rt_valid),
        .rt_res            (rt_res),
        .mem_rdata         (mem_rdata),
        .interrupt_pending (interrupt_pending),
        .reg_we            (reg_we),
        .wr_data           (wr_data),
        .jump_out          (jump_out),
        .new_pc            (new_pc),
        .mem_we            (mem_we),
        .mem_waddr         (mem_waddr),
        .mem_wdata         (mem_wdata),
        .raise_exception   (raise_exception),
        .exception_code    (exception_code),
        .machine_return    (machine_return),
        .interrupt_ack     (interrupt_ack),
        .retire_tag        (retire_tag)
    );

endmodule

//--- verif/retire_assertions.sv
// Control-rule assertions for the back end, bound onto retire_top from the testbench
`timescale 1ns/1ps

module retire_assertions (
    input logic                             clk,
    input logic                             reset,
    input logic                             rt_valid,          // Internal to retire_top
    input retire_pkg::exec_res_t            rt_res,
    input logic                             interrupt_pending,
    input logic                             reg_we,
    input logic                             jump_out,
    input logic [3:0]                       mem_we,
    input logic                             raise_exception,
    input retire_pkg::except_code           exception_code,
    input logic                             machine_return,
    input logic                             interrupt_ack,
    input logic [retire_pkg::tag_width-1:0] retire_tag
);
    import retire_pkg::*;

    int   fail_count = 0;                                          // Failed assertions so far
    logic kept;                                                    // On the live path
    logic redirect;                                                // Any tag-advancing event

    assign kept     = rt_valid && rt_res.tag == retire_tag;
    assign redirect = jump_out || raise_exception || machine_return || interrupt_ack;

    // Quiet outputs and tag zero right after a reset edge
    reset_quiet: assert property (@(posedge clk) $past(reset) |->
        !reg_we && !redirect && mem_we == 4'b0000 && retire_tag == '0) else begin
        fail_count++;
        $error("retire outputs active after reset");
    end

    wrong_path_killed: assert property (@(posedge clk) disable iff (reset)
        rt_valid && !kept |-> !reg_we && !redirect && mem_we == 4'b0000) else begin
        fail_count++;
        $error("wrong-path instruction had an effect");
    end

    tag_advance: assert property (@(posedge clk) disable iff (reset)
        redirect |=> retire_tag == $past(retire_tag) + 4'd1) else begin
        fail_count++;
        $error("tag did not step after a redirect");
    end

    // Covers killed instructions too
    tag_hold: assert property (@(posedge clk) disable iff (reset)
        !redirect |=> retire_tag == $past(retire_tag)) else begin
        fail_count++;
        $error("tag moved without a redirect");
    end

    trap_code: assert property (@(posedge clk) disable iff (reset)
        kept && (rt_res.illegal || rt_res.iclass inside {ECALL, EBREAK}) |->
        raise_exception && exception_code == (rt_res.illegal ? ILLEGAL_INSTRUCTION :
        rt_res.iclass == ECALL ? ECALL_FROM_MMODE : BREAKPOINT)) else begin
        fail_count++;
        $error("exception missing or wrong code");
    end

    mret_taken: assert property (@(posedge clk) disable iff (reset)
        kept && !rt_res.illegal && rt_res.iclass == MRET |->
        machine_return && !raise_exception && !interrupt_ack) else begin
        fail_count++;
        $error("MRET not returned or outranked");
    end

    // Lowest priority, never with a jump
    irq_ack_rule: assert property (@(posedge clk) disable iff (reset)
        interrupt_ack |-> interrupt_pending && !jump_out && !raise_exception &&
        !machine_return) else begin
        fail_count++;
        $error("interrupt acknowledged against the priority rule");
    end

endmodule

//--- verif/tb_retire.sv
// Testbench for the back end: issues packets, models the data memory and checks retire results
`timescale 1ns/1ps

module tb_retire;
    import retire_pkg::*;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 issue;
    logic                 interrupt_pending;
    issue_t               issue_pkt;
    logic [xlen-1:0]      mem_rdata = '0;                   // Memory model output
    logic [xlen-1:0]      mem_raddr, wr_data, new_pc, mem_waddr, mem_wdata;
    logic                 mem_re, reg_we, jump_out, raise_exception, machine_return, interrupt_ack;
    logic [3:0]           mem_we;
    except_code           exception_code;
    logic [tag_width-1:0] retire_tag;
    int                   checks = 0;
    int                   errors = 0;
    instr_class           cls_list[14] = '{LB, LBU, LH, LHU, LW, SB, SH, SW,
                                           JAL_JALR, ADD_OP, ECALL, EBREAK, MRET, NOP};
    instr_class           ev_cls[6]    = '{ECALL, ECALL, EBREAK, MRET, NOP, JAL_JALR};
    except_code           ev_code[6]   = '{ILLEGAL_INSTRUCTION, ECALL_FROM_MMODE, BREAKPOINT,
                                           NE, NE, NE};
    logic [31:0]          ev_flags[6]  = '{8, 8, 8, 4, 2, 1};     // {raise, mret, ack, jump}

    always #4 clk = ~clk;                                   // 8 ns period

    retire_top u_dut (.*);

    bind retire_top retire_assertions u_assert (
        .clk(clk), .reset(reset), .rt_valid(rt_valid), .rt_res(rt_res),
        .interrupt_pending(interrupt_pending), .reg_we(reg_we), .jump_out(jump_out),
        .mem_we(mem_we), .raise_exception(raise_exception), .exception_code(exception_code),
        .machine_return(machine_return), .interrupt_ack(interrupt_ack), .retire_tag(retire_tag)
    );

    // Memory word is a hash of its full word address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    always @(posedge clk) begin
        if (mem_re)
            mem_rdata <= mem_word(mem_raddr);               // Read data one cycle after mem_re
    end

    function automatic logic [31:0] imm_i(input logic [31:0] w);
        return {{20{w[31]}}, w[31:20]};                     // RISC-V I-type bits
    endfunction

    function automatic logic [31:0] imm_s(input logic [31:0] w);
        return {{20{w[31]}}, w[31:25], w[11:7]};            // RISC-V S-type bits
    endfunction

    function automatic logic [31:0] align_mask(input instr_class cls);
        return (cls inside {LW, SW}) ? 32'h3 : (cls inside {LH, LHU, SH}) ? 32'h1 : 32'h0;
    endfunction

    function automatic logic [31:0] load_expect(input instr_class cls, input logic [31:0] addr);
        logic [31:0] word;
        logic [31:0] lane;
        word = mem_word({addr[31:2], 2'b00});
        lane = word >> (8 * addr[1:0]);                     // Addressed byte moved to bit 0
        case (cls)
            LB:      return {{24{lane[7]}}, lane[7:0]};
            LBU:     return {24'h0, lane[7:0]};
            LH:      return {{16{lane[15]}}, lane[15:0]};
            LHU:     return {16'h0, lane[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic issue_t make_pkt(input instr_class cls, input logic [tag_width-1:0] tag);
        issue_t p;
        p.pc      = $urandom & ~32'h3;
        p.rs1_val = $urandom;
        p.rs2_val = $urandom;
        p.instr   = $urandom;
        p.iclass  = cls;
        p.tag     = tag;
        p.illegal = 1'b0;
        p.we      = 1'b1;
        return p;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive(input issue_t pkt);
        @(posedge clk);
        issue     <= 1'b1;
        issue_pkt <= pkt;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        issue <= 1'b0;
    endtask

    // Steps over falling edges until the chosen output rises or the limit runs out
    task automatic wait_flag(input int sel, input string what);
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < 8 && !seen; n++) begin
            @(negedge clk);
            case (sel)
                0:       seen = reg_we;
                1:       seen = mem_we != 4'b0000;
                2:       seen = jump_out;
                default: seen = jump_out || raise_exception || machine_return || interrupt_ack;
            endcase
        end
        if (!seen) begin
            errors++;
            $display("Timed out at %0t ns waiting for %s", $time, what);
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        $display("test %-8s done, %0d errors", name, errors - err_start);
    endtask

    initial begin
        issue_t               pkt;
        instr_class           cls;
        logic [31:0]          addr;
        logic [tag_width-1:0] old;
        int                   err_start;
        int                   asserts;
        reset             = 1'b1;
        issue             = 1'b0;
        issue_pkt         = '0;
        interrupt_pending = 1'b0;
        void'($urandom(43227));
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        err_start = errors;
        @(negedge clk);
        compare_value("idle outputs", {22'h0, mem_re, reg_we, jump_out, raise_exception,
                      machine_return, interrupt_ack, mem_we}, 32'h0);
        compare_value("tag after reset", {28'h0, retire_tag}, 32'h0);
        end_test("reset", err_start);

        err_start = errors;
        for (int i = 0; i < 40; i++) begin
            cls         = cls_list[$urandom_range(4)];
            pkt         = make_pkt(cls, retire_tag);
            addr        = pkt.rs1_val + imm_i(pkt.instr);
            pkt.rs1_val = pkt.rs1_val - (addr & align_mask(cls));  // Natural alignment
            addr        = addr & ~align_mask(cls);
            drive(pkt);
            drive_idle();
            wait_flag(0, "load write-back");
            compare_value("load data", wr_data, load_expect(cls, addr));
        end
        end_test("loads", err_start);

        err_start = errors;
        for (int i = 0; i < 30; i++) begin
            cls         = cls_list[5 + $urandom_range(2)];
            pkt         = make_pkt(cls, retire_tag);
            pkt.we      = 1'b0;
            addr        = pkt.rs1_val + imm_s(pkt.instr);
            pkt.rs1_val = pkt.rs1_val - (addr & align_mask(cls));
            addr        = addr & ~align_mask(cls);
            drive(pkt);
            drive_idle();
            wait_flag(1, "store lanes");
            compare_value("store lanes", {28'h0, mem_we}, cls == SW ? 32'hf :
                          cls == SH ? 32'h3 << (2 * addr[1]) : 32'h1 << addr[1:0]);
            compare_value("store address", mem_waddr, addr);
            compare_value("store data", mem_wdata, pkt.rs2_val);
        end
        end_test("stores", err_start);

        err_start = errors;
        old       = retire_tag;
        @(posedge clk);
        interrupt_pending <= 1'b1;                          // Would be taken by a kept instruction
        for (int i = 0; i < 20; i++) begin
            pkt = make_pkt(cls_list[$urandom_range(13)],
                           retire_tag ^ tag_width'($urandom_range(15, 1)));
            pkt.illegal = 1'($urandom_range(1));
            drive(pkt);
            drive_idle();
            @(negedge clk);
            compare_value("killed outputs", {23'h0, reg_we, jump_out, raise_exception,
                          machine_return, interrupt_ack, mem_we}, 32'h0);
        end
        compare_value("tag after killed", {28'h0, retire_tag}, {28'h0, old});
        @(posedge clk);
        interrupt_pending <= 1'b0;
        end_test("killed", err_start);

        err_start = errors;
        for (int i = 0; i < 8; i++) begin
            old = retire_tag;
            pkt = make_pkt(JAL_JALR, old);
            drive(pkt);
            drive(make_pkt(ADD_OP, old));                   // Behind the jump with the old tag
            wait_flag(2, "jump");
            compare_value("jump target", new_pc, (pkt.rs1_val + imm_i(pkt.instr)) & ~32'h1);
            compare_value("link value", wr_data, pkt.pc + 32'd4);
            drive(make_pkt(SW, old));
            @(negedge clk);
            compare_value("tag after jump", {28'h0, retire_tag}, {28'h0, tag_width'(old + 1'b1)});
            compare_value("killed add", {31'h0, reg_we}, 32'h0);
            drive_idle();
            @(negedge clk);
            compare_value("killed store", {28'h0, mem_we}, 32'h0);
        end
        end_test("jumps", err_start);

        err_start = errors;
        for (int i = 0; i < 6; i++) begin
            old         = retire_tag;
            pkt         = make_pkt(ev_cls[i], old);
            pkt.illegal = (i == 0);                         // Illegal outranks ECALL
            drive(pkt);
            interrupt_pending <= 1'b1;                      // Pending under every event
            drive_idle();
            wait_flag(3, "trap or redirect");
            compare_value("exception code", {28'h0, exception_code}, {28'h0, ev_code[i]});
            compare_value("raise mret ack jump", {28'h0, raise_exception, machine_return,
                          interrupt_ack, jump_out}, ev_flags[i]);
            @(negedge clk);
            compare_value("tag after event", {28'h0, retire_tag}, {28'h0, tag_width'(old + 1'b1)});
        end
        @(posedge clk);
        interrupt_pending <= 1'b0;
        end_test("events", err_start);

        asserts = u_dut.u_assert.fail_count;
        $display("tests 6, checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, asserts);
        if (errors == 0 && asserts == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- build.f
rtl/retire_pkg.sv
rtl/exec_unit.sv
rtl/exec_retire_reg.sv
rtl/retire.sv
rtl/retire_top.sv
verif/retire_assertions.sv
verif/tb_retire.sv

//--- Makefile
# Verilator flow for the back-end testbench

TOP = tb_retire
SIM = obj_dir/V$(TOP)

all: run

$(SIM): build.f $(wildcard rtl/*.sv verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP)

run: $(SIM)
	$(SIM) +verilator+error+limit+1000 > sim.log 2>&1; rc=$$?; cat sim.log; test $$rc -eq 0
	@if grep -q "=== FAIL ===" sim.log; then echo "simulation reported errors"; exit 1; fi

lint:
	verilator --lint-only -Wall --top-module retire_top \
	    rtl/retire_pkg.sv rtl/exec_unit.sv rtl/exec_retire_reg.sv rtl/retire.sv rtl/retire_top.sv

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
